//--- cache_coherence_ctrl.sv
// --------------------
// MESI decisions for one command per cycle
// Array updates land on the edge ending the command cycle;
// bus, wb, put and L2 pulses follow one cycle later
// snoop_in is only meaningful with a CPU read miss
// --------------------

module cache_coherence_ctrl (
	input  logic                                            clk,
	input  logic                                            reset,
	input  logic                                            cmd_valid,
	input  cache_pkg::cmd_t                                 cmd,
	input  logic [cache_pkg::SET_BITS-1:0]                  set,
	input  logic [cache_pkg::TAG_BITS-1:0]                  tag,
	input  cache_pkg::snoop_t                               snoop_in,   // Other caches' answer
	input  logic                                            hit,
	input  logic [cache_pkg::WAY_BITS-1:0]                  hit_way,
	input  cache_pkg::mesi_t                                hit_state,
	input  logic [cache_pkg::WAY_BITS-1:0]                  victim_way,
	input  cache_pkg::mesi_t [cache_pkg::WAYS-1:0]          way_states,
	input  logic [cache_pkg::WAYS-1:0][cache_pkg::TAG_BITS-1:0] way_tags,
	output logic                                            tag_we,
	output logic [cache_pkg::WAY_BITS-1:0]                  wr_way,
	output cache_pkg::mesi_t                                wr_state,
	output logic [cache_pkg::TAG_BITS-1:0]                  wr_tag,
	output logic [1:0]                                      age_op,
	output logic [cache_pkg::WAY_BITS-1:0]                  age_way,
	output logic                                            clear_all,
	output logic                                            bus_valid,
	output cache_pkg::bus_op_t                              bus_op,
	output logic [cache_pkg::LINE_BITS-1:0]                 bus_addr,
	output logic                                            wb_valid,
	output logic [cache_pkg::LINE_BITS-1:0]                 wb_addr,
	output logic                                            put_valid,
	output cache_pkg::snoop_t                               put_result,
	output logic                                            l2_inv_valid,
	output logic [cache_pkg::LINE_BITS-1:0]                 l2_inv_addr,
	output logic [cache_pkg::COUNT_BITS-1:0]                read_count,
	output logic [cache_pkg::COUNT_BITS-1:0]                write_count,
	output logic [cache_pkg::COUNT_BITS-1:0]                hit_count,
	output logic [cache_pkg::COUNT_BITS-1:0]                miss_count
);

	import cache_pkg::*;

	logic                 cpu_access;             // CPU read or write this cycle
	logic [LINE_BITS-1:0] line_addr;              // Requested line
	logic [LINE_BITS-1:0] victim_addr;            // Line held by the victim way
	mesi_t                victim_state;
	logic                 bus_req, wb_req, put_req, l2_req;
	bus_op_t              bus_op_d;
	snoop_t               put_d;
	logic [LINE_BITS-1:0] wb_addr_d, l2_addr_d;

	assign cpu_access   = cmd_valid && (cmd == cpu_read || cmd == cpu_write);
	assign clear_all    = cmd_valid && (cmd == clear);
	assign line_addr    = {tag, set};
	assign victim_state = way_states[victim_way];
	assign victim_addr  = {way_tags[victim_way], set};

	// --------------------
	// Decision
	// --------------------
	always_comb begin
		tag_we    = 1'b0;
		wr_way    = hit_way;
		wr_state  = hit_state;
		wr_tag    = tag;
		age_op    = AGE_NONE;
		age_way   = hit_way;
		bus_req   = 1'b0;
		bus_op_d  = bus_read;
		wb_req    = 1'b0;
		wb_addr_d = line_addr;
		put_req   = 1'b0;
		put_d     = snp_nohit;
		l2_req    = 1'b0;
		l2_addr_d = line_addr;
		if (cmd_valid) begin
			case (cmd)
				cpu_read, cpu_write: begin
					if (hit) begin
						age_op = AGE_TOUCH;
						if (cmd == cpu_write) begin
							tag_we   = 1'b1;
							wr_state = st_m;           // E and M silent, S upgrades
							if (hit_state == st_s) begin
								bus_req  = 1'b1;
								bus_op_d = bus_invalidate;
							end
						end
					end else begin
						age_op  = AGE_FILL;            // Victim becomes youngest
						age_way = victim_way;
						tag_we  = 1'b1;
						wr_way  = victim_way;
						bus_req = 1'b1;
						if (victim_state != st_i) begin
							l2_req    = 1'b1;          // Inclusion, drop from L2
							l2_addr_d = victim_addr;
						end
						if (victim_state == st_m) begin
							wb_req    = 1'b1;          // Dirty victim
							wb_addr_d = victim_addr;
						end
						if (cmd == cpu_read) begin
							bus_op_d = bus_read;
							if (snoop_in == snp_nohit) begin
								wr_state = st_e;       // Nobody else holds it
							end else begin
								wr_state = st_s;
							end
						end else begin
							bus_op_d = bus_rwim;
							wr_state = st_m;
						end
					end
				end
				snoop_read, snoop_write, snoop_invalidate, snoop_rwim: begin
					put_req = 1'b1;
					if (hit) begin
						if (hit_state == st_m) begin
							put_d = snp_hitm;
						end else begin
							put_d = snp_hit;
						end
						case (cmd)
							snoop_read: begin
								tag_we   = 1'b1;
								wr_state = st_s;       // Share with requester
								wb_req   = (hit_state == st_m);
							end
							snoop_rwim: begin
								tag_we   = 1'b1;
								wr_state = st_i;
								wb_req   = (hit_state == st_m);
								l2_req   = 1'b1;
								age_op   = AGE_DEMOTE; // Freed way goes first
							end
							snoop_invalidate: begin
								if (hit_state == st_s) begin
									tag_we   = 1'b1;
									wr_state = st_i;
									l2_req   = 1'b1;
									age_op   = AGE_DEMOTE;
								end
							end
							default: ;                 // Snoop write, no change
						endcase
					end
				end
				default: ;                             // Idle or clear
			endcase
		end
	end

	// --------------------
	// Output pulses
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			bus_valid    <= 1'b0;
			wb_valid     <= 1'b0;
			put_valid    <= 1'b0;
			l2_inv_valid <= 1'b0;
		end else begin
			bus_valid    <= bus_req;
			wb_valid     <= wb_req;
			put_valid    <= put_req;
			l2_inv_valid <= l2_req;
		end
	end

	// Payload, held between pulses
	always_ff @(posedge clk) begin
		if (bus_req) begin
			bus_op   <= bus_op_d;
			bus_addr <= line_addr;
		end
		if (wb_req) begin
			wb_addr <= wb_addr_d;
		end
		if (put_req) begin
			put_result <= put_d;
		end
		if (l2_req) begin
			l2_inv_addr <= l2_addr_d;
		end
	end

	// --------------------
	// Statistics
	// --------------------
	always_ff @(posedge clk) begin
		if (reset || clear_all) begin
			read_count  <= '0;
			write_count <= '0;
			hit_count   <= '0;
			miss_count  <= '0;
		end else if (cpu_access) begin
			if (cmd == cpu_read) begin
				read_count <= read_count + 1'b1;
			end else begin
				write_count <= write_count + 1'b1;
			end
			if (hit) begin
				hit_count <= hit_count + 1'b1;
			end else begin
				miss_count <= miss_count + 1'b1;
			end
		end
	end

	// Dirty data leaves only by eviction (with L2 inv) or by a snoop
	a_wb_cause : assert property (
		@(posedge clk) disable iff (reset)
		wb_valid |-> (l2_inv_valid || put_valid)
	) else $error("ctrl: write-back without eviction or snoop");

endmodule : cache_coherence_ctrl

//--- cache_l3.sv
// --------------------
// L3 directory top, tags and MESI states only
// One command per cycle, outputs one cycle later
// No back-pressure; low offset bits are ignored
// --------------------

module cache_l3 (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            cmd_valid,    // One-cycle command strobe
	input  cache_pkg::cmd_t                 cmd,
	input  logic [cache_pkg::ADDR_BITS-1:0] addr,         // Byte address
	input  cache_pkg::snoop_t               snoop_in,     // Sampled with cmd
	output logic                            bus_valid,
	output cache_pkg::bus_op_t              bus_op,
	output logic [cache_pkg::LINE_BITS-1:0] bus_addr,
	output logic                            wb_valid,
	output logic [cache_pkg::LINE_BITS-1:0] wb_addr,
	output logic                            put_valid,
	output cache_pkg::snoop_t               put_result,
	output logic                            l2_inv_valid,
	output logic [cache_pkg::LINE_BITS-1:0] l2_inv_addr,
	output logic [cache_pkg::COUNT_BITS-1:0] read_count,
	output logic [cache_pkg::COUNT_BITS-1:0] write_count,
	output logic [cache_pkg::COUNT_BITS-1:0] hit_count,
	output logic [cache_pkg::COUNT_BITS-1:0] miss_count
);

	import cache_pkg::*;

	logic [SET_BITS-1:0]                set;
	logic [TAG_BITS-1:0]                tag;
	logic                               hit;
	logic [WAY_BITS-1:0]                hit_way;
	mesi_t                              hit_state;
	mesi_t [WAYS-1:0]                   way_states;
	logic [WAYS-1:0][TAG_BITS-1:0]      way_tags;
	logic [WAY_BITS-1:0]                victim_way;
	logic                               tag_we;
	logic [WAY_BITS-1:0]                wr_way;
	mesi_t                              wr_state;
	logic [TAG_BITS-1:0]                wr_tag;
	logic [1:0]                         age_op;
	logic [WAY_BITS-1:0]                age_way;
	logic                               clear_all;

	// Address split, tag over set over offset
	assign set = addr[OFFSET_BITS +: SET_BITS];
	assign tag = addr[OFFSET_BITS + SET_BITS +: TAG_BITS];

	cache_tag_store i_tag_store (
		.clk, .reset, .set, .tag, .tag_we, .wr_way, .wr_state, .wr_tag, .clear_all,
		.hit, .hit_way, .hit_state, .way_states, .way_tags
	);

	cache_lru i_lru (
		.clk, .reset, .set, .age_op, .age_way, .clear_all, .victim_way
	);

	cache_coherence_ctrl i_ctrl (
		.clk, .reset, .cmd_valid, .cmd, .set, .tag, .snoop_in,
		.hit, .hit_way, .hit_state, .victim_way, .way_states, .way_tags,
		.tag_we, .wr_way, .wr_state, .wr_tag, .age_op, .age_way, .clear_all,
		.bus_valid, .bus_op, .bus_addr, .wb_valid, .wb_addr,
		.put_valid, .put_result, .l2_inv_valid, .l2_inv_addr,
		.read_count, .write_count, .hit_count, .miss_count
	);

endmodule : cache_l3

//--- cache_lru.sv
// --------------------
// Per-set age counters, 0 youngest, WAYS-1 oldest
// Ages of a set always form a permutation of 0..WAYS-1
// Fill relies on modulo wrap, so WAYS is a power of two
// --------------------

module cache_lru (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [cache_pkg::SET_BITS-1:0] set,        // Addressed set
	input  logic [1:0]                     age_op,     // AGE_* rule to apply
	input  logic [cache_pkg::WAY_BITS-1:0] age_way,    // Way the rule is about
	input  logic                           clear_all,  // Restore initial ages
	output logic [cache_pkg::WAY_BITS-1:0] victim_way  // Oldest way of the set
);

	import cache_pkg::*;

	logic [WAY_BITS-1:0] age_q    [SETS][WAYS]; // Age per line
	logic [WAY_BITS-1:0] cur_age  [WAYS];       // Ages of addressed set
	logic [WAY_BITS-1:0] next_age [WAYS];       // Ages after the rule
	logic [WAY_BITS-1:0] ref_age;               // Age of age_way
	logic [WAYS-1:0]     is_oldest;

	// --------------------
	// Read and victim
	// --------------------
	always_comb begin
		victim_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			cur_age[w]   = age_q[set][w];
			is_oldest[w] = (cur_age[w] == WAY_BITS'(WAYS - 1));
			if (is_oldest[w]) begin
				victim_way = WAY_BITS'(w);
			end
		end
	end

	assign ref_age = cur_age[age_way];

	// --------------------
	// Update rules
	// --------------------
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			next_age[w] = cur_age[w]; // Default hold
			case (age_op)
				AGE_TOUCH: begin
					if (WAY_BITS'(w) == age_way) begin
						next_age[w] = '0; // Most recent
					end else if (cur_age[w] < ref_age) begin
						next_age[w] = cur_age[w] + 1'b1;
					end
				end
				AGE_FILL: begin
					next_age[w] = cur_age[w] + 1'b1; // Victim wraps to 0
				end
				AGE_DEMOTE: begin
					if (WAY_BITS'(w) == age_way) begin
						next_age[w] = WAY_BITS'(WAYS - 1); // Next victim
					end else if (cur_age[w] > ref_age) begin
						next_age[w] = cur_age[w] - 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset || clear_all) begin
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					age_q[s][w] <= WAY_BITS'(w); // Way w starts at age w
				end
			end
		end else if (age_op != AGE_NONE) begin
			for (int w = 0; w < WAYS; w++) begin
				age_q[set][w] <= next_age[w];
			end
		end
	end

	// Rules from the controller keep exactly one oldest way per set
	a_one_victim : assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(set) |-> $onehot(is_oldest)
	) else $error("lru: set %0d has no single oldest way", set);

endmodule : cache_lru

//--- cache_pkg.sv
// --------------------
// Shared geometry and encodings for the L3 directory
// SETS must stay a power of two, WAYS a power of two too,
// because age counters wrap modulo WAYS on a fill
// --------------------

package cache_pkg;

	// --------------------
	// Geometry
	// --------------------
	localparam int ADDR_BITS   = 32;                                 // Trace address width
	localparam int OFFSET_BITS = 6;                                  // 64-byte lines
	localparam int SET_BITS    = 4;                                  // Set index width
	localparam int SETS        = 1 << SET_BITS;                      // 16 sets
	localparam int TAG_BITS    = ADDR_BITS - SET_BITS - OFFSET_BITS; // 22
	localparam int WAYS        = 8;                                  // Associativity
	localparam int WAY_BITS    = $clog2(WAYS);                       // Way index and age width
	localparam int LINE_BITS   = TAG_BITS + SET_BITS;                // Line address, tag over set
	localparam int COUNT_BITS  = 32;                                 // Statistics counters

	// Age update rules, driven by the controller into the LRU unit
	localparam logic [1:0] AGE_NONE   = 2'd0; // Ages unchanged
	localparam logic [1:0] AGE_TOUCH  = 2'd1; // Hit way becomes youngest
	localparam logic [1:0] AGE_FILL   = 2'd2; // All age by one, victim wraps to 0
	localparam logic [1:0] AGE_DEMOTE = 2'd3; // Invalidated way becomes oldest

	// --------------------
	// Encodings
	// --------------------
	typedef enum logic [2:0] {
		cmd_none,         // Idle slot
		cpu_read,         // CPU data read
		cpu_write,        // CPU data write
		snoop_read,       // Other cache reads
		snoop_write,      // Other cache writes back
		snoop_invalidate, // Other cache upgrades S to M
		snoop_rwim,       // Other cache reads for ownership
		clear             // Invalidate whole directory
	} cmd_t;

	typedef enum logic [1:0] {
		st_i, // Invalid, never hits
		st_s, // Shared, clean
		st_e, // Exclusive, clean
		st_m  // Modified, dirty
	} mesi_t;

	typedef enum logic [1:0] {
		bus_read,       // Fill for a read miss
		bus_write,      // Data write on the bus
		bus_invalidate, // Upgrade of a shared line
		bus_rwim        // Fill with ownership for a write miss
	} bus_op_t;

	// Snoop answer, both the one we put and the one we sample
	typedef enum logic [1:0] {
		snp_nohit, // Line not held
		snp_hit,   // Held clean
		snp_hitm   // Held modified
	} snoop_t;

endpackage : cache_pkg

//--- cache_tag_store.sv
// --------------------
// Tag and MESI state arrays, one write per cycle
// Lookup of the addressed set is combinational
// A way hits only while its state is valid
// --------------------

module cache_tag_store (
	input  logic                                            clk,
	input  logic                                            reset,
	input  logic [cache_pkg::SET_BITS-1:0]                  set,        // Addressed set
	input  logic [cache_pkg::TAG_BITS-1:0]                  tag,        // Request tag
	input  logic                                            tag_we,     // Write one way
	input  logic [cache_pkg::WAY_BITS-1:0]                  wr_way,
	input  cache_pkg::mesi_t                                wr_state,
	input  logic [cache_pkg::TAG_BITS-1:0]                  wr_tag,
	input  logic                                            clear_all,  // Invalidate all sets
	output logic                                            hit,
	output logic [cache_pkg::WAY_BITS-1:0]                  hit_way,
	output cache_pkg::mesi_t                                hit_state,
	output cache_pkg::mesi_t [cache_pkg::WAYS-1:0]          way_states, // Whole set, for victim
	output logic [cache_pkg::WAYS-1:0][cache_pkg::TAG_BITS-1:0] way_tags
);

	import cache_pkg::*;

	// --------------------
	// Storage
	// --------------------
	mesi_t                state_q [SETS][WAYS]; // Coherence state per line
	logic [TAG_BITS-1:0]  tag_q   [SETS][WAYS]; // Tag per line
	logic [WAYS-1:0]      match;                // Valid and tag equal, per way

	// State array, cleared by reset or clear command
	always_ff @(posedge clk) begin
		if (reset || clear_all) begin
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					state_q[s][w] <= st_i;
				end
			end
		end else if (tag_we) begin
			state_q[set][wr_way] <= wr_state; // New MESI state
		end
	end

	// Tag array
	always_ff @(posedge clk) begin
		if (tag_we) begin
			tag_q[set][wr_way] <= wr_tag; // Same tag on a pure state change
		end
	end

	// --------------------
	// Lookup
	// --------------------
	always_comb begin
		hit     = 1'b0;
		hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			way_states[w] = state_q[set][w];
			way_tags[w]   = tag_q[set][w];
			match[w]      = (state_q[set][w] != st_i) && (tag_q[set][w] == tag);
			if (match[w]) begin
				hit     = 1'b1;
				hit_way = WAY_BITS'(w); // Single match expected
			end
		end
	end

	assign hit_state = way_states[hit_way]; // Meaningful only with hit

	// A tag is only filled on a miss, so no set ever holds it twice
	a_single_hit : assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(set) |-> $onehot0(match)
	) else $error("tag store: more than one way hits in set %0d", set);

endmodule : cache_tag_store

//--- filelist.f
+incdir+.
cache_pkg.sv
cache_tag_store.sv
cache_lru.sv
cache_coherence_ctrl.sv
cache_l3.sv
tb_cache_l3.sv

//--- tb_cache_model.svh
// --------------------
// Reference model of the L3 directory, included in the testbench module body
// Needs cache_pkg imported before the include
// Predictions land by non-blocking assignment, valid in the next cycle
// --------------------
`ifndef TB_CACHE_MODEL_SVH
`define TB_CACHE_MODEL_SVH

mesi_t                 m_state [SETS][WAYS];      // Model line states
logic [TAG_BITS-1:0]   m_tag   [SETS][WAYS];
int                    m_age   [SETS][WAYS];      // 0 youngest
int                    m_reads, m_writes, m_hits, m_misses;

// Expected outputs for the cycle after the command
logic                  exp_bus_valid, exp_wb_valid, exp_put_valid, exp_l2_valid;
bus_op_t               exp_bus_op;
snoop_t                exp_put;
logic [LINE_BITS-1:0]  exp_bus_addr, exp_wb_addr, exp_l2_addr;
logic [COUNT_BITS-1:0] exp_reads, exp_writes, exp_hits, exp_misses;

// Reset and clear look the same from outside
task automatic restart_model();
	for (int s = 0; s < SETS; s++) begin
		for (int w = 0; w < WAYS; w++) begin
			m_state[s][w] = st_i;
			m_age[s][w]   = w;                  // Way w starts at age w
		end
	end
	m_reads  = 0;
	m_writes = 0;
	m_hits   = 0;
	m_misses = 0;
endtask

function automatic int oldest_way(int s);
	int v;
	v = 0;
	for (int w = 0; w < WAYS; w++) begin
		if (m_age[s][w] == WAYS - 1) v = w;
	end
	return v;
endfunction

// Touch, fill or demote on one set
task automatic age_set(int s, int way, logic [1:0] rule);
	int ref_age;
	ref_age = m_age[s][way];
	for (int w = 0; w < WAYS; w++) begin
		if (rule == AGE_FILL) m_age[s][w] = (m_age[s][w] + 1) % WAYS;
		else if (w == way) m_age[s][w] = (rule == AGE_TOUCH) ? 0 : WAYS - 1;
		else if (rule == AGE_TOUCH && m_age[s][w] < ref_age) m_age[s][w]++;
		else if (rule == AGE_DEMOTE && m_age[s][w] > ref_age) m_age[s][w]--;
	end
endtask

task automatic model_step(input logic valid, input cmd_t c, input logic [ADDR_BITS-1:0] a,
		input snoop_t sn);
	int                   s;
	int                   way;
	int                   vic;
	bit                   found;
	mesi_t                st;
	logic [TAG_BITS-1:0]  t;
	logic [LINE_BITS-1:0] line;
	s     = int'(a[OFFSET_BITS +: SET_BITS]);
	t     = a[OFFSET_BITS + SET_BITS +: TAG_BITS];
	line  = {t, SET_BITS'(s)};
	found = 1'b0;
	way   = 0;
	for (int w = 0; w < WAYS; w++) begin
		if (m_state[s][w] != st_i && m_tag[s][w] == t) begin
			found = 1'b1;                       // Only valid ways hit
			way   = w;
		end
	end
	st            = m_state[s][way];
	exp_bus_valid <= 1'b0;                      // Pulses default low
	exp_wb_valid  <= 1'b0;
	exp_put_valid <= 1'b0;
	exp_l2_valid  <= 1'b0;
	if (valid) begin
		case (c)
			cpu_read, cpu_write: begin
				if (c == cpu_read) m_reads++;
				else m_writes++;
				if (found) begin
					m_hits++;
					age_set(s, way, AGE_TOUCH);
					if (c == cpu_write && st == st_s) begin
						exp_bus_valid <= 1'b1;      // Upgrade S to M
						exp_bus_op    <= bus_invalidate;
						exp_bus_addr  <= line;
					end
					if (c == cpu_write) m_state[s][way] = st_m;
				end else begin
					m_misses++;
					vic = oldest_way(s);
					if (m_state[s][vic] != st_i) begin
						exp_l2_valid <= 1'b1;       // Victim leaves L2 too
						exp_l2_addr  <= {m_tag[s][vic], SET_BITS'(s)};
					end
					if (m_state[s][vic] == st_m) begin
						exp_wb_valid <= 1'b1;       // Dirty victim
						exp_wb_addr  <= {m_tag[s][vic], SET_BITS'(s)};
					end
					age_set(s, vic, AGE_FILL);
					m_tag[s][vic] = t;
					exp_bus_valid <= 1'b1;
					exp_bus_addr  <= line;
					exp_bus_op    <= (c == cpu_read) ? bus_read : bus_rwim;
					if (c == cpu_write) m_state[s][vic] = st_m;
					else m_state[s][vic] = (sn == snp_nohit) ? st_e : st_s;
				end
			end
			snoop_read, snoop_write, snoop_invalidate, snoop_rwim: begin
				exp_put_valid <= 1'b1;
				exp_put       <= !found ? snp_nohit : (st == st_m) ? snp_hitm : snp_hit;
				if (found && st == st_m && (c == snoop_read || c == snoop_rwim)) begin
					exp_wb_valid <= 1'b1;           // Dirty line snooped out
					exp_wb_addr  <= line;
				end
				if (found && c == snoop_read) m_state[s][way] = st_s;
				if (found && (c == snoop_rwim || (c == snoop_invalidate && st == st_s))) begin
					exp_l2_valid <= 1'b1;
					exp_l2_addr  <= line;
					m_state[s][way] = st_i;
					age_set(s, way, AGE_DEMOTE);    // Freed way is next victim
				end
			end
			clear: restart_model();
			default: ;
		endcase
	end
	exp_reads  <= COUNT_BITS'(m_reads);
	exp_writes <= COUNT_BITS'(m_writes);
	exp_hits   <= COUNT_BITS'(m_hits);
	exp_misses <= COUNT_BITS'(m_misses);
endtask

`endif

//--- tb_cache_l3.sv
// --------------------
// Testbench for cache_l3, random tags from a fixed seed
// Output pulses and counters checked by concurrent assertions
// against the model in tb_cache_model.svh
// --------------------
module tb_cache_l3;
	import cache_pkg::*;

	localparam int PERIOD   = 8;
	localparam int MAX_CMDS = 100;                      // Commands plus idle slots, upper bound

	logic                  clk, reset, cmd_valid;
	cmd_t                  cmd;
	logic [ADDR_BITS-1:0]  addr;
	snoop_t                snoop_in;
	logic                  bus_valid, wb_valid, put_valid, l2_inv_valid;
	bus_op_t               bus_op;
	snoop_t                put_result;
	logic [LINE_BITS-1:0]  bus_addr, wb_addr, l2_inv_addr;
	logic [COUNT_BITS-1:0] read_count, write_count, hit_count, miss_count;
	int                    seed = 4713;
	int                    mismatches, failures;
	string                 test_name = "reset";
	logic [TAG_BITS-1:0]   base;                        // Tags are base plus index, distinct

	`include "tb_cache_model.svh"

	cache_l3 i_cache_l3 (.*);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	// Model follows every sampled command
	always @(posedge clk) begin
		if (reset) begin
			restart_model();
			model_step(1'b0, cmd_none, '0, snp_nohit);  // Zero predictions
		end else begin
			model_step(cmd_valid, cmd, addr, snoop_in);
		end
	end

	// --------------------
	// Checks
	// --------------------
	task automatic flag_pulse(string what, logic expected);
		failures++;
		$display("%s: %s pulse %s", test_name, what, expected ? "missing" : "unexpected");
	endtask

	task automatic show_mismatch(string what, logic [127:0] expected, logic [127:0] actual);
		mismatches++;
		$display("mismatch %s %s expected %0h actual %0h", test_name, what, expected, actual);
	endtask

	a_bus_pulse : assert property (@(posedge clk) disable iff (reset) bus_valid == exp_bus_valid)
		else flag_pulse("bus", $sampled(exp_bus_valid));
	a_wb_pulse : assert property (@(posedge clk) disable iff (reset) wb_valid == exp_wb_valid)
		else flag_pulse("write-back", $sampled(exp_wb_valid));
	a_put_pulse : assert property (@(posedge clk) disable iff (reset) put_valid == exp_put_valid)
		else flag_pulse("snoop result", $sampled(exp_put_valid));
	a_l2_pulse : assert property (@(posedge clk) disable iff (reset) l2_inv_valid == exp_l2_valid)
		else flag_pulse("L2 invalidate", $sampled(exp_l2_valid));

	a_bus_data : assert property (@(posedge clk) disable iff (reset)
		bus_valid && exp_bus_valid |-> {bus_op, bus_addr} == {exp_bus_op, exp_bus_addr})
		else show_mismatch("bus op/addr", $sampled({exp_bus_op, exp_bus_addr}),
			$sampled({bus_op, bus_addr}));
	a_wb_data : assert property (@(posedge clk) disable iff (reset)
		wb_valid && exp_wb_valid |-> wb_addr == exp_wb_addr)
		else show_mismatch("wb_addr", $sampled(exp_wb_addr), $sampled(wb_addr));
	a_put_data : assert property (@(posedge clk) disable iff (reset)
		put_valid && exp_put_valid |-> put_result == exp_put)
		else show_mismatch("put_result", $sampled(exp_put), $sampled(put_result));
	a_l2_data : assert property (@(posedge clk) disable iff (reset)
		l2_inv_valid && exp_l2_valid |-> l2_inv_addr == exp_l2_addr)
		else show_mismatch("l2_inv_addr", $sampled(exp_l2_addr), $sampled(l2_inv_addr));
	a_counts : assert property (@(posedge clk) disable iff (reset)
		{read_count, write_count, hit_count, miss_count}
			== {exp_reads, exp_writes, exp_hits, exp_misses})
		else show_mismatch("read/write/hit/miss", $sampled({exp_reads, exp_writes, exp_hits,
			exp_misses}), $sampled({read_count, write_count, hit_count, miss_count}));

	// --------------------
	// Stimulus
	// --------------------
	task automatic issue(cmd_t c, int idx, int s, snoop_t sn = snp_nohit);
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd       <= c;
		addr      <= {TAG_BITS'(base + idx), SET_BITS'(s), OFFSET_BITS'($random(seed))};
		snoop_in  <= sn;                                // Only matters on a read miss
	endtask

	// Drain the last command before renaming the test
	task automatic start_test(string name);
		repeat (3) begin
			@(posedge clk);
			cmd_valid <= 1'b0;
			cmd       <= cmd_none;
		end
		test_name = name;
	endtask

	initial begin
		reset      = 1'b1;
		cmd_valid  = 1'b0;
		cmd        = cmd_none;
		addr       = '0;
		snoop_in   = snp_nohit;
		mismatches = 0;
		failures   = 0;
		base       = TAG_BITS'($random(seed));
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		start_test("read_miss");
		for (int i = 0; i < 3; i++) issue(cpu_read, i, 1, snoop_t'(i)); // E, S, S
		for (int i = 0; i < 3; i++) issue(cpu_read, i, 1);              // Hits
		start_test("write_hit");
		issue(cpu_write, 1, 1);                         // S, bus_invalidate
		issue(cpu_write, 0, 1);                         // E, silent
		issue(cpu_write, 2, 1);                         // S from HITM fill, bus_invalidate
		issue(snoop_read, 1, 1);
		issue(snoop_read, 0, 1);
		start_test("evict");
		issue(cpu_write, 10, 5);                        // Oldest fill, dirty
		for (int i = 11; i < 19; i++) issue(cpu_read, i, 5);
		start_test("snoop");
		issue(cpu_write, 20, 9);
		issue(snoop_write, 20, 9);                      // HITM, no change
		issue(snoop_read, 20, 9);                       // HITM, wb, to S
		issue(snoop_read, 20, 9);                       // Now HIT
		issue(cpu_read, 21, 9);
		issue(snoop_rwim, 21, 9);
		issue(cpu_read, 21, 9);                         // Misses again
		issue(cpu_write, 22, 9);
		issue(snoop_rwim, 22, 9);                       // HITM, wb, l2_inv
		issue(cpu_read, 23, 9, snp_hit);
		issue(snoop_invalidate, 23, 9);
		issue(snoop_read, 99, 9);                       // NOHIT
		start_test("demote");
		for (int i = 30; i < 38; i++) issue(cpu_read, i, 12);
		issue(snoop_rwim, 33, 12);
		issue(cpu_read, 38, 12);                        // Refills freed way, no l2_inv
		issue(cpu_read, 39, 12);
		start_test("clear");
		issue(clear, 0, 0);
		for (int i = 0; i < 3; i++) issue(cpu_read, i, 1);
		issue(cpu_read, 18, 5);
		issue(cpu_read, 38, 12);
		start_test("end");
		$display("summary: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches + failures == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#((MAX_CMDS + 4 + 20) * PERIOD);
		$display("timeout: stimulus did not finish in the expected time");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule : tb_cache_l3
